// File: verilog/axis_pkg.sv
// stream port definitions
`default_nettype none

package axis_pkg;

  ////////////////////
  // widths
  ////////////////////

  // data word on ingress and egress
  localparam int DATA_WIDTH = 32;

  // transaction id carried in tid
  localparam int ID_WIDTH   = 4;

  ////////////////////
  // types
  ////////////////////

  typedef logic [DATA_WIDTH-1:0] tdata_t;  // dividend, divisor or quotient
  typedef logic [ID_WIDTH-1:0]   tid_t;    // tags a divisor beat and its result

endpackage

`default_nettype wire

// File: verilog/div_pkg.sv
// divider arithmetic definitions
`default_nettype none

package div_pkg;

  ////////////////////
  // arithmetic widths
  ////////////////////

  // operands and quotient share the stream word width
  localparam int N_BITS = axis_pkg::DATA_WIDTH;

  // fraction bits of the fixed point format, top level can override
  localparam int Q_BITS_DEFAULT = 15;

  ////////////////////
  // records
  ////////////////////

  // one division job, built by the collector
  typedef struct packed {
    axis_pkg::tid_t    tid;       // id of the divisor beat
    logic [N_BITS-1:0] dividend;  // held from the tlast low beat
    logic [N_BITS-1:0] divisor;   // tlast high beat
  } operand_t;  // 68 bits

  // one finished division
  typedef struct packed {
    axis_pkg::tid_t    tid;       // copied from the operand record
    logic [N_BITS-1:0] quotient;  // all ones on overflow
    logic              overflow;  // zero divisor or quotient too wide
  } result_t;  // 37 bits

endpackage

`default_nettype wire

// File: verilog/operand_collector.sv
// operand beat collector
`timescale 1ns/1ps
`default_nettype none

module operand_collector (
  input  wire                      clk,
  input  wire                      rst_n,

  // ingress stream, two beats per job
  input  wire                      ing_tvalid,
  output logic                     ing_tready,
  input  wire  axis_pkg::tdata_t   ing_tdata,
  input  wire                      ing_tlast,   // low = dividend, high = divisor
  input  wire  axis_pkg::tid_t     ing_tid,

  // operand record towards the FIFO
  output logic                     op_valid,
  input  wire                      op_ready,
  output div_pkg::operand_t        op
);

  ////////////////////
  // handshake
  ////////////////////

  logic                          op_valid_q;  // record waiting for the FIFO
  div_pkg::operand_t             op_q;
  logic [div_pkg::N_BITS-1:0]    dividend_q;  // last dividend beat seen
  logic                          ing_fire;
  logic                          op_fire;

  // stall ingress only while a record sits unaccepted
  assign ing_tready = !op_valid_q || op_ready;

  assign ing_fire = ing_tvalid && ing_tready;
  assign op_fire  = op_valid_q && op_ready;

  assign op_valid = op_valid_q;
  assign op       = op_q;

  ////////////////////
  // control
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_valid_q <= 1'b0;
    end else if (ing_fire && ing_tlast) begin
      op_valid_q <= 1'b1;  // new record, may replace one leaving this edge
    end else if (op_fire) begin
      op_valid_q <= 1'b0;
    end
  end

  ////////////////////
  // payload
  ////////////////////

  always_ff @(posedge clk) begin
    if (ing_fire && !ing_tlast) begin
      dividend_q <= ing_tdata;  // kept until the next dividend beat
    end
    if (ing_fire && ing_tlast) begin
      // divisor beat closes the pair
      op_q.tid      <= ing_tid;
      op_q.dividend <= dividend_q;
      op_q.divisor  <= ing_tdata;
    end
  end

endmodule

`default_nettype wire

// File: verilog/sync_fifo.sv
// synchronous FIFO, typed payload
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type payload_t    = logic,
  parameter int  FIFO_DEPTH_P = 4
) (
  input  wire            clk,
  input  wire            rst_n,

  // push side
  input  wire            push_valid,
  output logic           push_ready,   // not full
  input  wire  payload_t push_data,

  // pop side
  output logic           pop_valid,    // not empty
  input  wire            pop_ready,
  output payload_t       pop_data
);

  localparam int PTR_W = (FIFO_DEPTH_P > 1) ? $clog2(FIFO_DEPTH_P) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH_P + 1);

  payload_t          mem [FIFO_DEPTH_P];  // circular storage
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;               // entries held
  logic              push_fire;
  logic              pop_fire;

  // wraps at depth, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(FIFO_DEPTH_P - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  ////////////////////
  // flags
  ////////////////////

  assign push_ready = (count != CNT_W'(FIFO_DEPTH_P));
  assign pop_valid  = (count != '0);
  assign pop_data   = mem[rd_ptr];  // head entry, seen one cycle after push

  assign push_fire = push_valid && push_ready;
  assign pop_fire  = pop_valid && pop_ready;

  ////////////////////
  // pointers, count
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop_fire) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none, or push and pop together
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push_fire) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/long_division_core.sv
// restoring fixed point divider
`timescale 1ns/1ps
`default_nettype none

module long_division_core #(
  parameter int Q_BITS_P = div_pkg::Q_BITS_DEFAULT
) (
  input  wire                       clk,
  input  wire                       rst_n,

  // operand side
  input  wire                       in_valid,
  output logic                      in_ready,  // idle only
  input  wire  div_pkg::operand_t   in_op,

  // result side
  output logic                      res_valid,
  input  wire                       res_ready,
  output div_pkg::result_t          res
);

  localparam int N     = div_pkg::N_BITS;
  localparam int NQ    = N + Q_BITS_P;         // quotient bits produced
  localparam int CNT_W = $clog2(NQ + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,   // one quotient bit per cycle
    ST_FINAL,  // overflow check and result register
    ST_DONE    // hold result until taken
  } state_t;

  state_t             state_q;
  logic [CNT_W-1:0]   cnt_q;      // bits still to produce
  logic [NQ-1:0]      num_q;      // dividend << Q shifted out msb first
  logic [N-1:0]       den_q;
  logic [N-1:0]       rem_q;      // partial remainder, stays internal
  logic [NQ-1:0]      quo_q;      // full width quotient
  axis_pkg::tid_t     tid_q;
  div_pkg::result_t   res_q;

  logic [N:0]         rem_shift;  // remainder with next numerator bit
  logic [N-1:0]       rem_diff;
  logic               q_bit;
  logic               ovf;

  ////////////////////
  // datapath
  ////////////////////

  assign rem_shift = {rem_q, num_q[NQ-1]};
  assign rem_diff  = rem_shift[N-1:0] - den_q;  // exact whenever q_bit is set
  assign q_bit     = (rem_shift >= {1'b0, den_q});  // always set for den 0

  // anything above bit N-1 means the quotient does not fit
  assign ovf = (den_q == '0) || ((quo_q >> N) != '0);

  assign in_ready  = (state_q == ST_IDLE);
  assign res_valid = (state_q == ST_DONE);
  assign res       = res_q;

  ////////////////////
  // control
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (in_valid) begin
            state_q <= ST_BUSY;
            cnt_q   <= CNT_W'(NQ);
          end
        end
        ST_BUSY: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == CNT_W'(1)) begin
            state_q <= ST_FINAL;  // last bit this edge
          end
        end
        ST_FINAL: begin
          state_q <= ST_DONE;
        end
        ST_DONE: begin
          if (res_ready) begin
            state_q <= ST_IDLE;  // stalls here under back-pressure
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // working registers
  always_ff @(posedge clk) begin
    case (state_q)
      ST_IDLE: begin
        if (in_valid) begin
          num_q <= NQ'(in_op.dividend) << Q_BITS_P;  // append fraction zeros
          den_q <= in_op.divisor;
          rem_q <= '0;
          quo_q <= '0;
          tid_q <= in_op.tid;
        end
      end
      ST_BUSY: begin
        rem_q <= q_bit ? rem_diff : rem_shift[N-1:0];  // restore on 0
        num_q <= num_q << 1;
        quo_q <= {quo_q[NQ-2:0], q_bit};
      end
      ST_FINAL: begin
        res_q.tid      <= tid_q;
        res_q.quotient <= ovf ? '1 : quo_q[N-1:0];  // saturate
        res_q.overflow <= ovf;
      end
      default: begin
        res_q <= res_q;  // result held in done
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/long_division_axis.sv
// streaming divider top
`timescale 1ns/1ps
`default_nettype none

module long_division_axis #(
  parameter int Q_BITS_P     = div_pkg::Q_BITS_DEFAULT,
  parameter int FIFO_DEPTH_P = 4
) (
  input  wire                     clk,
  input  wire                     rst_n,

  // ingress, dividend then divisor
  input  wire                     ing_tvalid,
  output logic                    ing_tready,
  input  wire  axis_pkg::tdata_t  ing_tdata,
  input  wire                     ing_tlast,
  input  wire  axis_pkg::tid_t    ing_tid,

  // egress, one beat per result
  output logic                    egr_tvalid,
  input  wire                     egr_tready,
  output axis_pkg::tdata_t        egr_tdata,   // quotient
  output logic                    egr_tlast,
  output axis_pkg::tid_t          egr_tid,
  output logic                    egr_tuser    // overflow
);

  // collector to operand FIFO
  logic               op_valid;
  logic               op_ready;
  div_pkg::operand_t  op;

  // operand FIFO to core
  logic               core_in_valid;
  logic               core_in_ready;
  div_pkg::operand_t  core_in_op;

  // core to result FIFO
  logic               res_valid;
  logic               res_ready;
  div_pkg::result_t   res;

  // result FIFO head
  div_pkg::result_t   egr_res;

  ////////////////////
  // egress unpack
  ////////////////////

  assign egr_tdata = egr_res.quotient;
  assign egr_tid   = egr_res.tid;
  assign egr_tuser = egr_res.overflow;
  assign egr_tlast = 1'b1;  // every result is a single beat packet

  operand_collector operand_collector_i0 (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .ing_tvalid ( ing_tvalid ),
    .ing_tready ( ing_tready ),
    .ing_tdata  ( ing_tdata  ),
    .ing_tlast  ( ing_tlast  ),
    .ing_tid    ( ing_tid    ),
    .op_valid   ( op_valid   ),
    .op_ready   ( op_ready   ),
    .op         ( op         )
  );

  sync_fifo #(
    .payload_t    ( div_pkg::operand_t ),
    .FIFO_DEPTH_P ( FIFO_DEPTH_P       )
  ) operand_fifo_i0 (
    .clk        ( clk           ),
    .rst_n      ( rst_n         ),
    .push_valid ( op_valid      ),
    .push_ready ( op_ready      ),
    .push_data  ( op            ),
    .pop_valid  ( core_in_valid ),
    .pop_ready  ( core_in_ready ),
    .pop_data   ( core_in_op    )
  );

  long_division_core #(
    .Q_BITS_P ( Q_BITS_P )
  ) long_division_core_i0 (
    .clk       ( clk           ),
    .rst_n     ( rst_n         ),
    .in_valid  ( core_in_valid ),
    .in_ready  ( core_in_ready ),
    .in_op     ( core_in_op    ),
    .res_valid ( res_valid     ),
    .res_ready ( res_ready     ),
    .res       ( res           )
  );

  sync_fifo #(
    .payload_t    ( div_pkg::result_t ),
    .FIFO_DEPTH_P ( FIFO_DEPTH_P      )
  ) result_fifo_i0 (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .push_valid ( res_valid  ),
    .push_ready ( res_ready  ),
    .push_data  ( res        ),
    .pop_valid  ( egr_tvalid ),
    .pop_ready  ( egr_tready ),
    .pop_data   ( egr_res    )
  );

endmodule

`default_nettype wire

// File: dv/long_division_tb.sv
// streaming divider testbench
`timescale 1ns/1ps
`default_nettype none

module long_division_tb;

  localparam int Q_BITS    = div_pkg::Q_BITS_DEFAULT;  // dut runs with defaults
  localparam int TIMEOUT   = 400;                      // cycles per wait loop
  localparam int BURST_LEN = 40;

  logic              clk;
  logic              rst_n;
  logic              ing_tvalid;
  logic              ing_tready;
  axis_pkg::tdata_t  ing_tdata;
  logic              ing_tlast;
  axis_pkg::tid_t    ing_tid;
  logic              egr_tvalid;
  logic              egr_tready;
  axis_pkg::tdata_t  egr_tdata;
  logic              egr_tlast;
  axis_pkg::tid_t    egr_tid;
  logic              egr_tuser;

  int value_errors;
  int timeouts;

  long_division_axis dut (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .ing_tvalid ( ing_tvalid ),
    .ing_tready ( ing_tready ),
    .ing_tdata  ( ing_tdata  ),
    .ing_tlast  ( ing_tlast  ),
    .ing_tid    ( ing_tid    ),
    .egr_tvalid ( egr_tvalid ),
    .egr_tready ( egr_tready ),
    .egr_tdata  ( egr_tdata  ),
    .egr_tlast  ( egr_tlast  ),
    .egr_tid    ( egr_tid    ),
    .egr_tuser  ( egr_tuser  )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  ////////////////////
  // reporting
  ////////////////////

  task automatic finish_run();
    $display("checks done: %0d value errors, %0d timeouts", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    timeouts++;
    finish_run();
  endtask

  task automatic check_quotient(input string name, input axis_pkg::tdata_t exp,
                                input axis_pkg::tdata_t act);
    if (exp !== act) begin
      $display("[FAIL] %s: expected %h, got %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_tid(input string name, input axis_pkg::tid_t exp,
                           input axis_pkg::tid_t act);
    if (exp !== act) begin
      $display("[FAIL] %s: expected %h, got %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[FAIL] %s: expected %b, got %b", name, exp, act);
      value_errors++;
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  // floor(dividend * 2^q / divisor) saturating when it needs more than 32 bits
  function automatic void model_divide(input axis_pkg::tdata_t dividend,
                                       input axis_pkg::tdata_t divisor,
                                       output axis_pkg::tdata_t q, output logic ovf);
    logic [63:0] wide;
    if (divisor == '0) begin
      q   = '1;
      ovf = 1'b1;
    end else begin
      wide = {32'd0, dividend} << Q_BITS;  // at most 47 bits
      wide = wide / {32'd0, divisor};
      ovf  = (wide[63:32] != '0);
      q    = ovf ? '1 : wide[31:0];
    end
  endfunction

  task automatic expect_result(input string name, input axis_pkg::tdata_t dividend,
                               input axis_pkg::tdata_t divisor, input axis_pkg::tid_t exp_id,
                               input axis_pkg::tdata_t q, input axis_pkg::tid_t id,
                               input logic ovf, input logic last);
    axis_pkg::tdata_t exp_q;
    logic             exp_ovf;
    model_divide(dividend, divisor, exp_q, exp_ovf);
    check_quotient({name, " quotient"}, exp_q, q);
    check_tid({name, " tid"}, exp_id, id);
    check_flag({name, " tuser"}, exp_ovf, ovf);
    check_flag({name, " tlast"}, 1'b1, last);
  endtask

  ////////////////////
  // stream drivers
  ////////////////////

  // send one ingress beat and return just after the accepting edge with tvalid still high
  task automatic send_beat(input axis_pkg::tdata_t data, input logic last,
                           input axis_pkg::tid_t id);
    int   waited;
    logic taken;
    waited     = 0;
    taken      = 1'b0;
    ing_tvalid = 1'b1;
    ing_tdata  = data;
    ing_tlast  = last;
    ing_tid    = id;
    while (!taken && waited < TIMEOUT) begin
      @(negedge clk);
      taken = ing_tready;  // settled mid cycle so the next edge transfers
      @(posedge clk);
      #1;
      waited++;
    end
    if (!taken) report_timeout("ingress handshake");
  endtask

  // take one egress beat with tready randomized each cycle under stall
  task automatic receive_result(input logic stall, output axis_pkg::tdata_t q,
                                output axis_pkg::tid_t id, output logic ovf,
                                output logic last);
    int   waited;
    logic got;
    waited = 0;
    got    = 1'b0;
    while (!got && waited < TIMEOUT) begin
      @(negedge clk);
      if (egr_tvalid && egr_tready) begin
        q    = egr_tdata;
        id   = egr_tid;
        ovf  = egr_tuser;
        last = egr_tlast;
        got  = 1'b1;
      end
      @(posedge clk);
      #1;
      if (stall) egr_tready = 1'($urandom_range(0, 1));
      waited++;
    end
    if (!got) report_timeout("egress result");
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic run_directed(input string name, input axis_pkg::tdata_t dividend,
                              input axis_pkg::tdata_t divisor, input axis_pkg::tid_t id);
    axis_pkg::tdata_t q;
    axis_pkg::tid_t   rid;
    logic             ovf;
    logic             last;
    send_beat(dividend, 1'b0, '0);
    send_beat(divisor, 1'b1, id);
    ing_tvalid = 1'b0;
    receive_result(1'b0, q, rid, ovf, last);
    expect_result(name, dividend, divisor, id, q, rid, ovf, last);
    if (divisor == '0 || name == "too_large") begin
      check_flag({name, " overflow set"}, 1'b1, ovf);  // overflow forces all ones
      check_quotient({name, " saturated"}, '1, q);
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_flag("reset egr_tvalid", 1'b0, egr_tvalid);
    check_flag("reset ing_tready", 1'b1, ing_tready);
    @(posedge clk);
    #1;
  endtask

  task automatic test_random_burst();
    axis_pkg::tdata_t dividends [BURST_LEN];
    axis_pkg::tdata_t divisors  [BURST_LEN];
    axis_pkg::tdata_t q;
    axis_pkg::tid_t   id;
    logic             ovf;
    logic             last;
    for (int i = 0; i < BURST_LEN; i++) begin
      dividends[i] = $urandom >> $urandom_range(0, 31);  // spread magnitudes
      divisors[i]  = $urandom >> $urandom_range(0, 31);
      if (i % 13 == 5) divisors[i] = '0;
    end
    fork
      begin  // back to back pairs
        for (int i = 0; i < BURST_LEN; i++) begin
          send_beat(dividends[i], 1'b0, '0);
          send_beat(divisors[i], 1'b1, axis_pkg::tid_t'(i % 16));
        end
        ing_tvalid = 1'b0;
      end
      begin  // in order under random egress stalls
        for (int j = 0; j < BURST_LEN; j++) begin
          receive_result(1'b1, q, id, ovf, last);
          expect_result($sformatf("random_burst_%0d", j), dividends[j], divisors[j],
                        axis_pkg::tid_t'(j % 16), q, id, ovf, last);
        end
      end
    join
    egr_tready = 1'b1;
  endtask

  // two divisors share one dividend beat
  task automatic test_held_dividend();
    axis_pkg::tdata_t q;
    axis_pkg::tid_t   id;
    logic             ovf;
    logic             last;
    send_beat(32'd500, 1'b0, '0);
    send_beat(32'd7, 1'b1, 4'h3);
    send_beat(32'd9, 1'b1, 4'h4);
    ing_tvalid = 1'b0;
    receive_result(1'b0, q, id, ovf, last);
    expect_result("held_first", 32'd500, 32'd7, 4'h3, q, id, ovf, last);
    receive_result(1'b0, q, id, ovf, last);
    expect_result("held_second", 32'd500, 32'd9, 4'h4, q, id, ovf, last);
  endtask

  initial begin
    void'($urandom(86587));
    value_errors = 0;
    timeouts     = 0;
    rst_n        = 1'b0;
    ing_tvalid   = 1'b0;
    ing_tdata    = '0;
    ing_tlast    = 1'b0;
    ing_tid      = '0;
    egr_tready   = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset_state();
    run_directed("int_100_div_4", 32'd100, 32'd4, 4'h1);
    run_directed("frac_1_div_3", 32'd1, 32'd3, 4'h2);
    run_directed("frac_7_div_2", 32'd7, 32'd2, 4'h5);
    run_directed("div_by_zero", 32'd1234, 32'd0, 4'h9);
    run_directed("too_large", 32'hFFFF_0000, 32'd3, 4'hA);
    test_random_burst();
    test_held_dividend();
    finish_run();
  end

endmodule

`default_nettype wire

// File: long_division_axis.f
verilog/axis_pkg.sv
verilog/div_pkg.sv
verilog/operand_collector.sv
verilog/sync_fifo.sv
verilog/long_division_core.sv
verilog/long_division_axis.sv
dv/long_division_tb.sv

// File: Makefile
# Verilator build for the streaming divider

VERILATOR  ?= verilator
FILELIST   := long_division_axis.f
TB_TOP     := long_division_tb
RTL_TOP    := long_division_axis
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := *** PASSED ***
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

# lint the design with the testbench, RTL top selected
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
